/* hdl/channel_access.sv */
`timescale 1ns/1ps
`include "tx_mac_cfg.svh"

module channel_access (
    input  logic clk,
    input  logic rst,
    input  logic cardet,
    input  logic access_req,
    output logic access_ack
);

    localparam int DIFS_W = $clog2(`TX_DIFS_CYCLES + 1);
    localparam int SLOT_W = $clog2(`TX_SLOT_CYCLES + 1);

    typedef enum logic [1:0] {
        CA_IDLE,
        CA_DIFS,
        CA_BACKOFF,
        CA_GRANT
    } ca_state_t;

    ca_state_t         state;
    logic [7:0]        lfsr;
    logic [DIFS_W-1:0] difs_cnt;
    logic [SLOT_W-1:0] slot_cyc;
    logic [7:0]        slots;

    assign access_ack = (state == CA_GRANT);

    // x^8 + x^6 + x^5 + x^4 + 1, maximal length.
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= 8'hA5;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    ////////////////////////////////////////////////////////////
    // DIFS wait, slot backoff and grant
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= CA_IDLE;
            difs_cnt <= '0;
            slot_cyc <= '0;
            slots    <= '0;
        end else begin
            case (state)
                CA_IDLE: begin
                    difs_cnt <= '0;
                    if (access_req) begin
                        state <= CA_DIFS;
                    end
                end
                CA_DIFS: begin
                    // Any carrier restarts the clear-channel count.
                    if (cardet) begin
                        difs_cnt <= '0;
                    end else if (difs_cnt == DIFS_W'(`TX_DIFS_CYCLES - 1)) begin
                        slots    <= lfsr & 8'(`TX_CW_MASK);
                        slot_cyc <= '0;
                        state    <= CA_BACKOFF;
                    end else begin
                        difs_cnt <= difs_cnt + 1'b1;
                    end
                end
                CA_BACKOFF: begin
                    // Countdown freezes while the medium is busy.
                    if (slots == '0) begin
                        state <= CA_GRANT;
                    end else if (!cardet) begin
                        if (slot_cyc == SLOT_W'(`TX_SLOT_CYCLES - 1)) begin
                            slot_cyc <= '0;
                            slots    <= slots - 1'b1;
                        end else begin
                            slot_cyc <= slot_cyc + 1'b1;
                        end
                    end
                end
                CA_GRANT: begin
                    if (!access_req) begin
                        state <= CA_IDLE;
                    end
                end
                default: state <= CA_IDLE;
            endcase
        end
    end

endmodule

/* hdl/fcs_crc8.sv */
`timescale 1ns/1ps
`include "tx_mac_cfg.svh"

module fcs_crc8 (
    input  logic               clk,
    input  logic               rst,
    input  logic               clr,
    input  logic               en,
    input  tx_mac_pkg::byte_t  data,
    output tx_mac_pkg::byte_t  crc
);

    // One byte folded in bit by bit, MSB first.
    function automatic tx_mac_pkg::byte_t crc_step(
        input tx_mac_pkg::byte_t cur,
        input tx_mac_pkg::byte_t din
    );
        tx_mac_pkg::byte_t c;
        c = cur ^ din;
        for (int i = 0; i < 8; i++) begin
            if (c[7]) begin
                c = (c << 1) ^ `TX_CRC_POLY;
            end else begin
                c = c << 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            crc <= `TX_CRC_INIT;
        end else if (en) begin
            crc <= crc_step(crc, data);
        end
    end

endmodule

/* hdl/frame_buffer.sv */
`timescale 1ns/1ps
`include "tx_mac_cfg.svh"

module frame_buffer (
    input  logic                   clk,
    input  tx_mac_pkg::buf_wr_t    wr,
    input  logic                   rd_en,
    input  tx_mac_pkg::buf_addr_t  rd_addr,
    output tx_mac_pkg::byte_t      rd_data
);

    localparam int DEPTH = 1 << `TX_BUF_AW;

    tx_mac_pkg::byte_t mem [DEPTH];

    ////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////

    // The register keeps its byte between reads, which lets the
    // modulator see stable data under back-pressure.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* hdl/tiu_fsm.sv */
`timescale 1ns/1ps
`include "tx_mac_cfg.svh"

module tiu_fsm (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     xvalid,
    input  tx_mac_pkg::byte_t        xdata,
    input  logic                     xsend,
    input  tx_mac_pkg::byte_t        dest_addr,
    input  tx_mac_pkg::frame_type_t  ftype,
    input  tx_mac_pkg::byte_t        mac,
    input  logic                     mx_rdy,
    input  logic                     ack_received,
    input  logic                     access_ack,
    input  tx_mac_pkg::byte_t        rd_data,
    input  tx_mac_pkg::byte_t        crc,
    output logic                     xrdy,
    output logic                     xbusy,
    output logic                     mx_valid,
    output tx_mac_pkg::byte_t        mx_data,
    output tx_mac_pkg::err_cnt_t     xerrcnt,
    output tx_mac_pkg::buf_wr_t      buf_wr,
    output logic                     rd_en,
    output tx_mac_pkg::buf_addr_t    rd_addr,
    output logic                     crc_clr,
    output logic                     crc_en,
    output logic                     access_req
);

    localparam int WD_W = $clog2(`TX_ACK_TIMEOUT);
    localparam int AT_W = $clog2(`TX_MAX_ATTEMPTS) + 1;

    localparam tx_mac_pkg::buf_addr_t PRE_LAST  = tx_mac_pkg::buf_addr_t'(`TX_PREAMBLE_LEN - 1);
    localparam tx_mac_pkg::buf_addr_t HDR_LAST  = tx_mac_pkg::buf_addr_t'(2);
    localparam tx_mac_pkg::buf_addr_t DATA_LAST = tx_mac_pkg::buf_addr_t'(`TX_MAX_DATA - 1);

    typedef enum logic [3:0] {
        IDLE,
        LOAD_PREAMBLE,
        LOAD_SFD,
        LOAD_HDR,
        LOAD_DATA,
        LOAD_FCS,
        ACCESS,
        RELEASE,
        TRANSMIT,
        ACK_WAIT
    } state_t;

    state_t state;
    state_t next;

    tx_mac_pkg::tx_req_t   req;
    tx_mac_pkg::buf_addr_t wr_addr;
    tx_mac_pkg::buf_addr_t end_addr;
    tx_mac_pkg::buf_addr_t cnt;
    tx_mac_pkg::buf_addr_t rd_ptr;
    logic [WD_W-1:0]       wdog;
    logic [AT_W-1:0]       attempts;
    logic                  fetch;

    logic mx_accept;
    logic last_byte;
    logic ack_req;
    logic wd_done;
    logic last_attempt;

    assign mx_accept    = mx_valid && mx_rdy;
    assign last_byte    = (rd_ptr == end_addr);
    assign ack_req      = (req.ftype == tx_mac_pkg::frame_type_t'(1));
    assign wd_done      = (wdog == WD_W'(`TX_ACK_TIMEOUT - 1));
    assign last_attempt = (attempts == AT_W'(`TX_MAX_ATTEMPTS - 1));

    // The read register holds the byte, so it feeds the modulator directly.
    assign mx_data    = rd_data;
    assign xbusy      = (state != IDLE);
    assign access_req = (state == ACCESS);

    ////////////////////////////////////////////////////////////
    // Next state and per-cycle controls
    ////////////////////////////////////////////////////////////

    always_comb begin
        next        = state;
        xrdy        = 1'b0;
        buf_wr.en   = 1'b0;
        buf_wr.addr = wr_addr;
        buf_wr.data = xdata;
        crc_clr     = 1'b0;
        crc_en      = 1'b0;
        rd_en       = 1'b0;
        rd_addr     = rd_ptr + 1'b1;

        case (state)
            IDLE: begin
                if (xvalid) begin
                    crc_clr = 1'b1;
                    next    = LOAD_PREAMBLE;
                end
            end
            LOAD_PREAMBLE: begin
                buf_wr.en   = 1'b1;
                buf_wr.data = `TX_PREAMBLE_BYTE;
                if (cnt == PRE_LAST) begin
                    next = LOAD_SFD;
                end
            end
            LOAD_SFD: begin
                buf_wr.en   = 1'b1;
                buf_wr.data = `TX_SFD_BYTE;
                next        = LOAD_HDR;
            end
            LOAD_HDR: begin
                // Destination, own address and type, all covered by the FCS.
                buf_wr.en = 1'b1;
                crc_en    = 1'b1;
                case (cnt)
                    '0:      buf_wr.data = req.dest;
                    'd1:     buf_wr.data = mac;
                    default: buf_wr.data = req.ftype;
                endcase
                if (cnt == HDR_LAST) begin
                    next = LOAD_DATA;
                end
            end
            LOAD_DATA: begin
                xrdy      = 1'b1;
                buf_wr.en = xvalid;
                crc_en    = xvalid;
                if (xvalid && (xsend || cnt == DATA_LAST)) begin
                    next = LOAD_FCS;
                end
            end
            LOAD_FCS: begin
                buf_wr.en   = 1'b1;
                buf_wr.data = crc;
                next        = ACCESS;
            end
            ACCESS: begin
                if (access_ack) begin
                    next = RELEASE;
                end
            end
            RELEASE: begin
                // Start fetching byte 0 once the handshake has fully closed.
                if (!access_ack) begin
                    rd_en   = 1'b1;
                    rd_addr = '0;
                    next    = TRANSMIT;
                end
            end
            TRANSMIT: begin
                if (mx_accept) begin
                    if (last_byte) begin
                        next = ack_req ? ACK_WAIT : IDLE;
                    end else begin
                        rd_en = 1'b1;
                    end
                end
            end
            ACK_WAIT: begin
                if (ack_received) begin
                    next = IDLE;
                end else if (wd_done) begin
                    next = last_attempt ? IDLE : ACCESS;
                end
            end
            default: next = IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            wr_addr  <= '0;
            cnt      <= '0;
            rd_ptr   <= '0;
            wdog     <= '0;
            attempts <= '0;
            fetch    <= 1'b0;
            mx_valid <= 1'b0;
            xerrcnt  <= '0;
        end else begin
            state <= next;
            fetch <= rd_en;

            if (state == IDLE) begin
                wr_addr <= '0;
            end else if (buf_wr.en) begin
                wr_addr <= wr_addr + 1'b1;
            end

            // Field counter restarts on every state change.
            if (next != state) begin
                cnt <= '0;
            end else if (buf_wr.en) begin
                cnt <= cnt + 1'b1;
            end

            if (state == RELEASE) begin
                rd_ptr <= '0;
            end else if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            // Valid rises the cycle after read data has landed.
            if (fetch) begin
                mx_valid <= 1'b1;
            end else if (mx_accept) begin
                mx_valid <= 1'b0;
            end

            if (state == ACK_WAIT) begin
                wdog <= wdog + 1'b1;
            end else begin
                wdog <= '0;
            end

            if (state == IDLE) begin
                attempts <= '0;
            end else if (state == ACK_WAIT && !ack_received && wd_done) begin
                attempts <= attempts + 1'b1;
                if (last_attempt) begin
                    xerrcnt <= xerrcnt + 1'b1;
                end
            end
        end
    end

    // The frame description is taken at frame start, the end address at the FCS write.
    always_ff @(posedge clk) begin
        if (state == IDLE && xvalid) begin
            req.dest  <= dest_addr;
            req.ftype <= ftype;
        end
        if (state == LOAD_FCS) begin
            end_addr <= wr_addr;
        end
    end

endmodule

/* hdl/tiu_top.sv */
`timescale 1ns/1ps
`include "tx_mac_cfg.svh"

module tiu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     xvalid,
    input  tx_mac_pkg::byte_t        xdata,
    input  logic                     xsend,
    input  tx_mac_pkg::byte_t        dest_addr,
    input  tx_mac_pkg::frame_type_t  ftype,
    input  tx_mac_pkg::byte_t        mac,
    input  logic                     cardet,
    input  logic                     ack_received,
    input  logic                     mx_rdy,
    output logic                     xrdy,
    output logic                     xbusy,
    output logic                     mx_valid,
    output tx_mac_pkg::byte_t        mx_data,
    output tx_mac_pkg::err_cnt_t     xerrcnt
);

    tx_mac_pkg::buf_wr_t   buf_wr;
    tx_mac_pkg::buf_addr_t rd_addr;
    tx_mac_pkg::byte_t     rd_data;
    tx_mac_pkg::byte_t     crc;
    logic                  rd_en;
    logic                  crc_clr;
    logic                  crc_en;
    logic                  access_req;
    logic                  access_ack;

    tiu_fsm tiu_fsm_inst (
        .clk          (clk),
        .rst          (rst),
        .xvalid       (xvalid),
        .xdata        (xdata),
        .xsend        (xsend),
        .dest_addr    (dest_addr),
        .ftype        (ftype),
        .mac          (mac),
        .mx_rdy       (mx_rdy),
        .ack_received (ack_received),
        .access_ack   (access_ack),
        .rd_data      (rd_data),
        .crc          (crc),
        .xrdy         (xrdy),
        .xbusy        (xbusy),
        .mx_valid     (mx_valid),
        .mx_data      (mx_data),
        .xerrcnt      (xerrcnt),
        .buf_wr       (buf_wr),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .crc_clr      (crc_clr),
        .crc_en       (crc_en),
        .access_req   (access_req)
    );

    frame_buffer frame_buffer_inst (
        .clk     (clk),
        .wr      (buf_wr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // The CRC sees exactly the byte being written to the buffer.
    fcs_crc8 fcs_crc8_inst (
        .clk  (clk),
        .rst  (rst),
        .clr  (crc_clr),
        .en   (crc_en),
        .data (buf_wr.data),
        .crc  (crc)
    );

    channel_access channel_access_inst (
        .clk        (clk),
        .rst        (rst),
        .cardet     (cardet),
        .access_req (access_req),
        .access_ack (access_ack)
    );

endmodule

/* hdl/tx_mac_pkg.sv */
`include "tx_mac_cfg.svh"

package tx_mac_pkg;

    ////////////////////////////////////////////////////////////
    // Basic vector types
    ////////////////////////////////////////////////////////////

    typedef logic [7:0] byte_t;

    typedef logic [`TX_BUF_AW-1:0] buf_addr_t;

    // Wraps on overflow.
    typedef logic [7:0] err_cnt_t;

    // Only the value 1 asks for an acknowledgement.
    typedef logic [7:0] frame_type_t;

    ////////////////////////////////////////////////////////////
    // Grouped signals
    ////////////////////////////////////////////////////////////

    // Frame description captured when a frame starts.
    typedef struct packed {
        byte_t       dest;
        frame_type_t ftype;
    } tx_req_t;

    typedef struct packed {
        logic      en;
        buf_addr_t addr;
        byte_t     data;
    } buf_wr_t;

endpackage

/* include/tx_mac_cfg.svh */
`ifndef TX_MAC_CFG_SVH
`define TX_MAC_CFG_SVH

// Frame layout constants.
`define TX_PREAMBLE_LEN   2
`define TX_PREAMBLE_BYTE  8'h55
`define TX_SFD_BYTE       8'hD0
`define TX_MAX_DATA       16

// 32 entries hold the largest frame of 23 bytes.
`define TX_BUF_AW         5

// Channel access timing, all in clock cycles.
`define TX_DIFS_CYCLES    16
`define TX_SLOT_CYCLES    4
`define TX_CW_MASK        15

// Acknowledgement window and retry limit.
`define TX_ACK_TIMEOUT    64
`define TX_MAX_ATTEMPTS   3

// CRC-8, MSB first, no reflection.
`define TX_CRC_POLY       8'h07
`define TX_CRC_INIT       8'h00

`endif

/* sim/tiu_tb.sv */
`timescale 1ns/1ps
`include "tx_mac_cfg.svh"

module tiu_tb;

    localparam int FRAME_MAX   = `TX_PREAMBLE_LEN + 5 + `TX_MAX_DATA;
    localparam int LOAD_WORST  = 2 * (FRAME_MAX + 4);
    localparam int ACCESS_MAX  = `TX_DIFS_CYCLES + `TX_CW_MASK * `TX_SLOT_CYCLES + 8;
    localparam int ATTEMPT_MAX = ACCESS_MAX + 8 * FRAME_MAX + `TX_ACK_TIMEOUT;
    localparam int BUSY_HOLD   = 40;
    localparam int GAP         = `TX_ACK_TIMEOUT + 24;
    // Five frames, seven attempts in all, plus carrier hold and idle gaps.
    localparam int CYCLE_LIMIT =
        2 * (10 + 5 * LOAD_WORST + 7 * ATTEMPT_MAX + BUSY_HOLD + 6 * GAP);

    logic                    clk;
    logic                    rst;
    logic                    xvalid;
    tx_mac_pkg::byte_t       xdata;
    logic                    xsend;
    tx_mac_pkg::byte_t       dest_addr;
    tx_mac_pkg::frame_type_t ftype;
    tx_mac_pkg::byte_t       mac;
    logic                    cardet;
    logic                    ack_received;
    logic                    mx_rdy;
    logic                    xrdy;
    logic                    xbusy;
    logic                    mx_valid;
    tx_mac_pkg::byte_t       mx_data;
    tx_mac_pkg::err_cnt_t    xerrcnt;

    int         cycles;
    logic [7:0] payload_q[$];
    logic [7:0] exp_q[$];
    logic [7:0] rx_q[$];

    tiu_top tiu_top_inst (
        .clk          (clk),
        .rst          (rst),
        .xvalid       (xvalid),
        .xdata        (xdata),
        .xsend        (xsend),
        .dest_addr    (dest_addr),
        .ftype        (ftype),
        .mac          (mac),
        .cardet       (cardet),
        .ack_received (ack_received),
        .mx_rdy       (mx_rdy),
        .xrdy         (xrdy),
        .xbusy        (xbusy),
        .mx_valid     (mx_valid),
        .mx_data      (mx_data),
        .xerrcnt      (xerrcnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Modulator side and run limit
    ////////////////////////////////////////////////////////////

    // Ready about three cycles in four.
    always @(posedge clk) begin
        mx_rdy <= (($urandom % 4) != 0);
    end

    // Values are settled at the falling edge, ahead of the DUT's sampling edge.
    always @(negedge clk) begin
        if (!rst && mx_valid && mx_rdy) begin
            rx_q.push_back(mx_data);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %0t %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // Bit-serial CRC-8, MSB first.
    function automatic logic [7:0] crc_update(input logic [7:0] crc_in, input logic [7:0] d);
        logic [7:0] c;
        logic       fb;
        c = crc_in;
        for (int b = 7; b >= 0; b--) begin
            fb = c[7] ^ d[b];
            c  = {c[6:0], 1'b0};
            if (fb) begin
                c = c ^ `TX_CRC_POLY;
            end
        end
        return c;
    endfunction

    task automatic fill_payload(input int n);
        payload_q.delete();
        for (int i = 0; i < n; i++) begin
            payload_q.push_back(8'($urandom));
        end
    endtask

    task automatic build_expected(input logic [7:0] dst, input logic [7:0] typ, input int n);
        logic [7:0] c;
        exp_q.delete();
        for (int i = 0; i < `TX_PREAMBLE_LEN; i++) begin
            exp_q.push_back(`TX_PREAMBLE_BYTE);
        end
        exp_q.push_back(`TX_SFD_BYTE);
        exp_q.push_back(dst);
        exp_q.push_back(mac);
        exp_q.push_back(typ);
        for (int i = 0; i < n; i++) begin
            exp_q.push_back(payload_q[i]);
        end
        c = `TX_CRC_INIT;
        for (int i = `TX_PREAMBLE_LEN + 1; i < exp_q.size(); i++) begin
            c = crc_update(c, exp_q[i]);
        end
        exp_q.push_back(c);
    endtask

    // Offers n bytes and stops early when the DUT closes the payload phase.
    task automatic drive_payload(input logic [7:0] dst, input logic [7:0] typ, input int n,
                                 input logic use_send, output int n_acc);
        int   i;
        logic done;
        i    = 0;
        done = 1'b0;
        @(posedge clk);
        dest_addr <= dst;
        ftype     <= typ;
        xvalid    <= 1'b1;
        xdata     <= payload_q[0];
        xsend     <= use_send && (n == 1);
        while (!done) begin
            @(negedge clk);
            if (xrdy) begin
                i++;
                @(posedge clk);
                if (i < n) begin
                    xdata <= payload_q[i];
                    xsend <= use_send && (i == n - 1);
                end else begin
                    xvalid <= 1'b0;
                    xsend  <= 1'b0;
                    done = 1'b1;
                end
            end else if (i > 0) begin
                @(posedge clk);
                xvalid <= 1'b0;
                xsend  <= 1'b0;
                done = 1'b1;
            end
        end
        n_acc = i;
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clk);
        end while (xbusy);
    endtask

    task automatic wait_bytes(input int n);
        while (rx_q.size() < n) begin
            @(posedge clk);
        end
    endtask

    task automatic compare_copy(input int base);
        for (int i = 0; i < exp_q.size(); i++) begin
            check_val($sformatf("mx_data byte %0d", base + i), exp_q[i], rx_q[base + i]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        @(negedge clk);
        check_val("xrdy", 0, xrdy);
        check_val("xbusy", 0, xbusy);
        check_val("mx_valid", 0, mx_valid);
        check_val("xerrcnt", 0, xerrcnt);
    endtask

    task automatic send_type0_frame();
        int n;
        int n_acc;
        n = 1 + ($urandom % `TX_MAX_DATA);
        rx_q.delete();
        fill_payload(n);
        build_expected(8'hA1, 8'h00, n);
        drive_payload(8'hA1, 8'h00, n, 1'b1, n_acc);
        check_val("accepted bytes", n, n_acc);
        wait_idle();
        check_val("frame length", exp_q.size(), rx_q.size());
        compare_copy(0);
    endtask

    task automatic cap_long_payload();
        int n_acc;
        rx_q.delete();
        fill_payload(`TX_MAX_DATA + 4);
        drive_payload(8'hB2, 8'h00, `TX_MAX_DATA + 4, 1'b0, n_acc);
        check_val("accepted bytes", `TX_MAX_DATA, n_acc);
        check_val("xrdy", 0, xrdy);
        build_expected(8'hB2, 8'h00, `TX_MAX_DATA);
        wait_idle();
        check_val("frame length", exp_q.size(), rx_q.size());
        compare_copy(0);
    endtask

    task automatic defer_on_carrier();
        int n_acc;
        rx_q.delete();
        fill_payload(5);
        build_expected(8'hC3, 8'h00, 5);
        @(posedge clk);
        cardet <= 1'b1;
        drive_payload(8'hC3, 8'h00, 5, 1'b1, n_acc);
        check_val("accepted bytes", 5, n_acc);
        repeat (BUSY_HOLD) begin
            @(negedge clk);
            check_val("mx_valid", 0, mx_valid);
        end
        @(posedge clk);
        cardet <= 1'b0;
        repeat (`TX_DIFS_CYCLES) begin
            @(negedge clk);
            check_val("mx_valid", 0, mx_valid);
        end
        wait_idle();
        check_val("frame length", exp_q.size(), rx_q.size());
        compare_copy(0);
    endtask

    task automatic confirm_with_ack();
        int         n_acc;
        logic [7:0] err_before;
        err_before = xerrcnt;
        rx_q.delete();
        fill_payload(7);
        build_expected(8'hD4, 8'h01, 7);
        drive_payload(8'hD4, 8'h01, 7, 1'b1, n_acc);
        check_val("accepted bytes", 7, n_acc);
        wait_bytes(exp_q.size());
        repeat (5) @(posedge clk);
        ack_received <= 1'b1;
        @(posedge clk);
        ack_received <= 1'b0;
        wait_idle();
        // A missed acknowledgement would show up as a second copy here.
        repeat (GAP) @(negedge clk);
        check_val("frame length", exp_q.size(), rx_q.size());
        compare_copy(0);
        check_val("xerrcnt", err_before, xerrcnt);
        check_val("xbusy", 0, xbusy);
    endtask

    task automatic retry_without_ack();
        int         n_acc;
        logic [7:0] err_before;
        err_before = xerrcnt;
        rx_q.delete();
        fill_payload(4);
        build_expected(8'hE5, 8'h01, 4);
        drive_payload(8'hE5, 8'h01, 4, 1'b1, n_acc);
        check_val("accepted bytes", 4, n_acc);
        wait_idle();
        check_val("frame length", `TX_MAX_ATTEMPTS * exp_q.size(), rx_q.size());
        for (int k = 0; k < `TX_MAX_ATTEMPTS; k++) begin
            compare_copy(k * exp_q.size());
        end
        check_val("xerrcnt", 8'(err_before + 1), xerrcnt);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(97927));
        cycles       = 0;
        rst          = 1'b1;
        xvalid       = 1'b0;
        xdata        = '0;
        xsend        = 1'b0;
        dest_addr    = '0;
        ftype        = '0;
        mac          = 8'h3C;
        cardet       = 1'b0;
        ack_received = 1'b0;
        mx_rdy       = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        check_reset_state();
        send_type0_frame();
        cap_long_payload();
        defer_on_carrier();
        confirm_with_ack();
        retry_without_ack();

        $display("test passed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
hdl/tx_mac_pkg.sv
hdl/fcs_crc8.sv
hdl/frame_buffer.sv
hdl/channel_access.sv
hdl/tiu_fsm.sv
hdl/tiu_top.sv
sim/tiu_tb.sv
